/* src/mul_settings.svh */
`ifndef MUL_SETTINGS_SVH
`define MUL_SETTINGS_SVH

// physical register tag width
`define MUL_TAG_W 8

`define MUL_PC_W 32

// cycles from accepted start to exit
`define MUL_DEPTH 5

// wide enough to hold MUL_DEPTH
`define MUL_CNT_W 3

`endif

/* src/mul_op_pkg.sv */
`default_nettype none

package mul_op_pkg;

    // multiply op select, low product or one of three high variants
    typedef enum logic [1:0] {
        MUL_LO    = 2'b00,
        MUL_HI_SS = 2'b01,
        MUL_HI_SU = 2'b10,
        MUL_HI_UU = 2'b11
    } mul_op_e;

    typedef struct packed {
        logic [31:0] hi;
        logic [31:0] lo;
    } product_halves_t;

    // full 64-bit product, or its two halves
    typedef union packed {
        logic [63:0]     word;
        product_halves_t half;
    } product_u;

endpackage

`default_nettype wire

/* src/mul_wb_pkg.sv */
`default_nettype none
`include "mul_settings.svh"

package mul_wb_pkg;

    // physical destination register
    typedef logic [`MUL_TAG_W-1:0] tag_t;

    typedef logic [`MUL_PC_W-1:0] pc_t;

endpackage

`default_nettype wire

/* src/mul_operand_prep.sv */
`default_nettype none

module mul_operand_prep (
    input  mul_op_pkg::mul_op_e op,
    input  logic [31:0]         a,
    input  logic [31:0]         b,
    output logic [31:0]         mag_a,
    output logic [31:0]         mag_b,
    output logic                neg
);
    import mul_op_pkg::*;

    logic a_signed;
    logic b_signed;
    logic neg_a;
    logic neg_b;

    // low product is sign-agnostic, treat as unsigned
    assign a_signed = (op == MUL_HI_SS) || (op == MUL_HI_SU);
    assign b_signed = (op == MUL_HI_SS);

    assign neg_a = a_signed && a[31];
    assign neg_b = b_signed && b[31];

    // -2^31 wraps to 32'h8000_0000, which is 2^31 unsigned
    assign mag_a = neg_a ? (~a + 32'd1) : a;
    assign mag_b = neg_b ? (~b + 32'd1) : b;

    assign neg = neg_a ^ neg_b;

endmodule

`default_nettype wire

/* src/csa_tree_pipe.sv */
`default_nettype none
`include "mul_settings.svh"

module csa_tree_pipe (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 accept,
    input  logic [31:0]          mag_a,
    input  logic [31:0]          mag_b,
    input  logic                 neg_in,
    input  mul_op_pkg::mul_op_e  op_in,
    input  mul_wb_pkg::tag_t     tag_in,
    input  mul_wb_pkg::pc_t      pc_in,
    output logic                 exit,
    output mul_op_pkg::product_u product,
    output logic                 neg_out,
    output mul_op_pkg::mul_op_e  op_out,
    output mul_wb_pkg::tag_t     tag_out,
    output mul_wb_pkg::pc_t      pc_out
);
    import mul_op_pkg::*;
    import mul_wb_pkg::*;

    // 16 + 8 + 4 + 2 carry-save vectors, stage outputs packed back to back
    localparam int NVEC = 30;

    logic [63:0] pp     [32];
    logic [63:0] tree_d [NVEC];
    logic [63:0] tree_q [NVEC];

    logic [`MUL_DEPTH-1:0] valid_q;
    logic                  neg_q [`MUL_DEPTH];
    mul_op_e               op_q  [`MUL_DEPTH];
    tag_t                  tag_q [`MUL_DEPTH];
    pc_t                   pc_q  [`MUL_DEPTH];
    product_u              product_q;

    genvar gi;
    genvar gs;
    genvar gg;

    for (gi = 0; gi < 32; gi++) begin : g_pp
        assign pp[gi] = mag_b[gi] ? ({32'd0, mag_a} << gi) : 64'd0;
    end

    // each stage halves the vector count with 4:2 groups
    for (gs = 0; gs < 4; gs++) begin : g_stage
        localparam int OUT_BASE = 32 - (32 >> gs);

        for (gg = 0; gg < (8 >> gs); gg++) begin : g_grp
            logic [63:0] w0, w1, w2, w3;
            logic [63:0] s1, c1, s2, c2;

            if (gs == 0) begin : g_from_pp
                assign w0 = pp[4*gg];
                assign w1 = pp[4*gg+1];
                assign w2 = pp[4*gg+2];
                assign w3 = pp[4*gg+3];
            end else begin : g_from_reg
                localparam int IN_BASE = 32 - (64 >> gs);

                assign w0 = tree_q[IN_BASE+4*gg];
                assign w1 = tree_q[IN_BASE+4*gg+1];
                assign w2 = tree_q[IN_BASE+4*gg+2];
                assign w3 = tree_q[IN_BASE+4*gg+3];
            end

            // two 3:2 rows
            assign s1 = w0 ^ w1 ^ w2;
            assign c1 = ((w0 & w1) | (w1 & w2) | (w0 & w2)) << 1;
            assign s2 = s1 ^ c1 ^ w3;
            assign c2 = ((s1 & c1) | (c1 & w3) | (s1 & w3)) << 1;

            assign tree_d[OUT_BASE+2*gg]   = s2;
            assign tree_d[OUT_BASE+2*gg+1] = c2;
        end
    end

    always_ff @(posedge clk) begin
        // first level only loads on an accepted start
        if (accept) begin
            for (int i = 0; i < 16; i++) begin
                tree_q[i] <= tree_d[i];
            end
        end
        for (int i = 16; i < NVEC; i++) begin
            tree_q[i] <= tree_d[i];
        end
        product_q.word <= tree_q[NVEC-2] + tree_q[NVEC-1];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[`MUL_DEPTH-2:0], accept};
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            neg_q[0] <= neg_in;
            op_q[0]  <= op_in;
            tag_q[0] <= tag_in;
            pc_q[0]  <= pc_in;
        end
        for (int i = 1; i < `MUL_DEPTH; i++) begin
            neg_q[i] <= neg_q[i-1];
            op_q[i]  <= op_q[i-1];
            tag_q[i] <= tag_q[i-1];
            pc_q[i]  <= pc_q[i-1];
        end
    end

    assign exit    = valid_q[`MUL_DEPTH-1];
    assign product = product_q;
    assign neg_out = neg_q[`MUL_DEPTH-1];
    assign op_out  = op_q[`MUL_DEPTH-1];
    assign tag_out = tag_q[`MUL_DEPTH-1];
    assign pc_out  = pc_q[`MUL_DEPTH-1];

    // sideband depth has to match the four tree stages plus the final add
    exit_latency_a: assert property (@(posedge clk) disable iff (rst)
        accept |-> ##(`MUL_DEPTH) exit);

endmodule

`default_nettype wire

/* src/mul_result_select.sv */
`default_nettype none

module mul_result_select (
    input  mul_op_pkg::mul_op_e  op,
    input  logic                 neg,
    input  mul_op_pkg::product_u product,
    output logic [31:0]          result
);
    import mul_op_pkg::*;

    product_u signed_prod;

    // tree works on magnitudes, restore the sign over all 64 bits
    always_comb begin
        if (neg) begin
            signed_prod.word = ~product.word + 64'd1;
        end else begin
            signed_prod.word = product.word;
        end
    end

    always_comb begin
        if (op == MUL_LO) begin
            result = signed_prod.half.lo;
        end else begin
            result = signed_prod.half.hi;
        end
    end

endmodule

`default_nettype wire

/* src/mul_inflight_counter.sv */
`default_nettype none
`include "mul_settings.svh"

module mul_inflight_counter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inc,
    input  logic                  dec,
    output logic [`MUL_CNT_W-1:0] count
);
    localparam int CW = `MUL_CNT_W;

    logic [CW-1:0] count_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else begin
            case ({inc, dec})
                2'b10:   count_q <= count_q + CW'(1);
                2'b01:   count_q <= count_q - CW'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    assign count = count_q;

    // an exit always has a matching accept in the tree
    dec_nonzero_a: assert property (@(posedge clk) disable iff (rst)
        dec |-> count_q != '0);

    count_max_a: assert property (@(posedge clk) disable iff (rst)
        count_q <= CW'(`MUL_DEPTH));

endmodule

`default_nettype wire

/* src/mul_flush_fsm.sv */
`default_nettype none
`include "mul_settings.svh"

module mul_flush_fsm (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  flush,
    input  logic [`MUL_CNT_W-1:0] count,
    input  logic                  exit,
    output logic                  accept,
    output logic                  done_en,
    output logic                  draining
);
    localparam int CW = `MUL_CNT_W;

    typedef enum logic {
        ST_RUN,
        ST_DRAIN
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   work_left;

    // ops still in the tree after this edge, the exiting one is finished
    assign work_left = (count != CW'(exit));

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_RUN: begin
                if (flush && work_left) begin
                    state_d = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                if (count == '0 && !exit) begin
                    state_d = ST_RUN;
                end
            end
            default: state_d = ST_RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    assign accept   = start && !flush && (state_q == ST_RUN);
    assign done_en  = (state_q == ST_RUN);
    assign draining = (state_q == ST_DRAIN);

    no_accept_a: assert property (@(posedge clk) disable iff (rst)
        (draining || flush) |-> !accept);

endmodule

`default_nettype wire

/* src/mul_unit.sv */
`default_nettype none
`include "mul_settings.svh"

module mul_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  mul_op_pkg::mul_op_e op,
    input  logic [31:0]         a,
    input  logic [31:0]         b,
    input  mul_wb_pkg::tag_t    tag_in,
    input  mul_wb_pkg::pc_t     pc_in,
    input  logic                flush,
    output logic                done,
    output logic [31:0]         result,
    output mul_wb_pkg::tag_t    tag_out,
    output mul_wb_pkg::pc_t     pc_out,
    output logic                busy,
    output logic                draining
);
    import mul_op_pkg::*;

    logic [31:0]           mag_a;
    logic [31:0]           mag_b;
    logic                  neg;
    logic                  accept;
    logic                  done_en;
    logic                  exit;
    logic                  neg_out;
    mul_op_e               op_out;
    product_u              product;
    logic [`MUL_CNT_W-1:0] count;

    mul_operand_prep prep_i (
        .op    (op),
        .a     (a),
        .b     (b),
        .mag_a (mag_a),
        .mag_b (mag_b),
        .neg   (neg)
    );

    csa_tree_pipe tree_i (
        .clk     (clk),
        .rst     (rst),
        .accept  (accept),
        .mag_a   (mag_a),
        .mag_b   (mag_b),
        .neg_in  (neg),
        .op_in   (op),
        .tag_in  (tag_in),
        .pc_in   (pc_in),
        .exit    (exit),
        .product (product),
        .neg_out (neg_out),
        .op_out  (op_out),
        .tag_out (tag_out),
        .pc_out  (pc_out)
    );

    mul_result_select select_i (
        .op      (op_out),
        .neg     (neg_out),
        .product (product),
        .result  (result)
    );

    mul_inflight_counter counter_i (
        .clk   (clk),
        .rst   (rst),
        .inc   (accept),
        .dec   (exit),
        .count (count)
    );

    mul_flush_fsm fsm_i (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .flush    (flush),
        .count    (count),
        .exit     (exit),
        .accept   (accept),
        .done_en  (done_en),
        .draining (draining)
    );

    // squashed ops still leave the tree, just without a done
    assign done = exit && done_en;
    assign busy = (count != '0);

endmodule

`default_nettype wire

/* test/mul_unit_tb.sv */
`default_nettype none
`include "mul_settings.svh"

module mul_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import mul_op_pkg::*;
    import mul_wb_pkg::*;

    logic        clk;
    logic        rst;
    logic        start;
    mul_op_e     op;
    logic [31:0] a;
    logic [31:0] b;
    tag_t        tag_in;
    pc_t         pc_in;
    logic        flush;
    logic        done;
    logic [31:0] result;
    tag_t        tag_out;
    pc_t         pc_out;
    logic        busy;
    logic        draining;

    logic [31:0] lcg_state;
    tag_t        tag_seq;
    pc_t         pc_seq;
    int          value_errors;
    int          other_errors;

    // expected writeback, one entry per accepted start, in issue order
    logic [31:0] exp_result_q [$];
    tag_t        exp_tag_q [$];
    pc_t         exp_pc_q [$];

    mul_unit dut_i (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .op       (op),
        .a        (a),
        .b        (b),
        .tag_in   (tag_in),
        .pc_in    (pc_in),
        .flush    (flush),
        .done     (done),
        .result   (result),
        .tag_out  (tag_out),
        .pc_out   (pc_out),
        .busy     (busy),
        .draining (draining)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // 64-bit product per op, then pick the half
    function automatic logic [31:0] ref_mul(mul_op_e op_v, logic [31:0] a_v, logic [31:0] b_v);
        longint          sa;
        longint          sb;
        longint unsigned ua;
        longint unsigned ub;
        logic [63:0]     prod;
        sa = longint'($signed(a_v));
        sb = longint'($signed(b_v));
        ua = {32'd0, a_v};
        ub = {32'd0, b_v};
        case (op_v)
            MUL_HI_SS: prod = sa * sb;
            MUL_HI_SU: prod = sa * longint'(ub);
            default:   prod = ua * ub;
        endcase
        if (op_v == MUL_LO) begin
            return prod[31:0];
        end
        return prod[63:32];
    endfunction

    function automatic logic [31:0] corner(int i);
        case (i)
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'hffff_ffff;
            3:       return 32'h8000_0000;
            default: return 32'h7fff_ffff;
        endcase
    endfunction

    task automatic check_result(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_tag(string name, tag_t got, tag_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_pc(string name, pc_t got, pc_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            value_errors++;
        end
    endtask

    // outputs are all registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (!rst && done === 1'b1) begin
            if (exp_result_q.size() == 0) begin
                $display("done seen at %0t with no operation outstanding", $time);
                other_errors++;
            end else begin
                check_result("result", result, exp_result_q.pop_front());
                check_tag("tag_out", tag_out, exp_tag_q.pop_front());
                check_pc("pc_out", pc_out, exp_pc_q.pop_front());
            end
        end
    end

    task automatic drive_op(input mul_op_e op_v, input logic [31:0] a_v,
                            input logic [31:0] b_v, input logic expect_done);
        @(negedge clk);
        start  = 1'b1;
        op     = op_v;
        a      = a_v;
        b      = b_v;
        tag_in = tag_seq;
        pc_in  = pc_seq;
        if (expect_done) begin
            exp_result_q.push_back(ref_mul(op_v, a_v, b_v));
            exp_tag_q.push_back(tag_seq);
            exp_pc_q.push_back(pc_seq);
        end
        tag_seq = tag_seq + 1'b1;
        pc_seq  = pc_seq + 32'd4;
    endtask

    task automatic drive_idle();
        @(negedge clk);
        start = 1'b0;
        flush = 1'b0;
    endtask

    task automatic wait_for_done(output int cycles);
        cycles = 0;
        while (cycles < 4 * `MUL_DEPTH) begin
            @(negedge clk);
            start = 1'b0;
            cycles++;
            if (done === 1'b1) begin
                return;
            end
        end
        $display("timed out after %0d cycles waiting for done", cycles);
        other_errors++;
    endtask

    task automatic wait_until_idle();
        for (int n = 0; n < 200; n++) begin
            @(negedge clk);
            start = 1'b0;
            if (exp_result_q.size() == 0 && busy === 1'b0) begin
                return;
            end
        end
        $display("timed out waiting for the pipeline to empty");
        other_errors++;
    endtask

    task automatic reset_state_test();
        check_bit("done", done, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_bit("draining", draining, 1'b0);
    endtask

    task automatic single_lo_test();
        int cycles;
        drive_op(MUL_LO, lcg_next(), lcg_next(), 1'b1);
        wait_for_done(cycles);
        check_result("done latency", cycles, `MUL_DEPTH);
        // the op is counted until the edge after its done
        check_bit("busy", busy, 1'b1);
        drive_idle();
        check_bit("busy", busy, 1'b0);
        wait_until_idle();
    endtask

    task automatic high_ops_test();
        mul_op_e op_v;
        for (int k = 1; k < 4; k++) begin
            op_v = mul_op_e'(k);
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    drive_op(op_v, corner(i), corner(j), 1'b1);
                end
            end
            for (int r = 0; r < 10; r++) begin
                drive_op(op_v, lcg_next(), lcg_next(), 1'b1);
            end
        end
        wait_until_idle();
    endtask

    task automatic back_to_back_test();
        logic [31:0] r;
        // first done lands MUL_DEPTH falling edges after its start
        for (int i = 0; i < 20; i++) begin
            r = lcg_next();
            drive_op(mul_op_e'(r[31:30]), lcg_next(), lcg_next(), 1'b1);
            check_bit("done", done, i >= `MUL_DEPTH);
        end
        for (int j = 0; j < `MUL_DEPTH; j++) begin
            drive_idle();
            check_bit("done", done, 1'b1);
        end
        drive_idle();
        check_bit("done", done, 1'b0);
        wait_until_idle();
    endtask

    task automatic flush_test();
        int n;
        int cycles;
        for (int i = 0; i < 3; i++) begin
            drive_op(mul_op_e'(i), lcg_next(), lcg_next(), 1'b0);
        end
        // start alongside the flush is dropped too
        drive_op(MUL_HI_UU, lcg_next(), lcg_next(), 1'b0);
        flush = 1'b1;
        drive_idle();
        check_bit("draining", draining, 1'b1);
        check_bit("busy", busy, 1'b1);
        for (n = 0; n < 30; n++) begin
            @(negedge clk);
            if (draining !== 1'b1) begin
                break;
            end
            check_bit("done", done, 1'b0);
            start = 1'b1;
            a     = lcg_next();
            b     = lcg_next();
        end
        start = 1'b0;
        if (n == 30) begin
            $display("timed out waiting for draining to fall");
            other_errors++;
        end
        check_bit("busy", busy, 1'b0);
        drive_op(MUL_HI_SS, lcg_next(), lcg_next(), 1'b1);
        wait_for_done(cycles);
        check_result("done latency", cycles, `MUL_DEPTH);
        wait_until_idle();
    endtask

    initial begin
        rst          = 1'b1;
        start        = 1'b0;
        op           = MUL_LO;
        a            = '0;
        b            = '0;
        tag_in       = '0;
        pc_in        = '0;
        flush        = 1'b0;
        lcg_state    = 32'hb26d;
        tag_seq      = 8'h10;
        pc_seq       = 32'h0000_1000;
        value_errors = 0;
        other_errors = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        reset_state_test();
        single_lo_test();
        high_ops_test();
        back_to_back_test();
        flush_test();

        $display("error counts: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mul_unit.f */
+incdir+src
src/mul_op_pkg.sv
src/mul_wb_pkg.sv
src/mul_operand_prep.sv
src/csa_tree_pipe.sv
src/mul_result_select.sv
src/mul_inflight_counter.sv
src/mul_flush_fsm.sv
src/mul_unit.sv
test/mul_unit_tb.sv

/* Bender.yml */
package:
  name: mul_unit

sources:
  - include_dirs:
      - src
    files:
      - src/mul_op_pkg.sv
      - src/mul_wb_pkg.sv
      - src/mul_operand_prep.sv
      - src/csa_tree_pipe.sv
      - src/mul_result_select.sv
      - src/mul_inflight_counter.sv
      - src/mul_flush_fsm.sv
      - src/mul_unit.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/mul_unit_tb.sv
